// ==== logic/synapse_defines.svh ====
`ifndef SYNAPSE_DEFINES_SVH
`define SYNAPSE_DEFINES_SVH

// word, code address and field widths.
`define WORD_W   16
`define IPR_W    16
`define DEST_W   6
`define SRC_W    10
// registers r0 to r7 live outside the core.
`define NUM_REGS 8

// control operators in the destination space.
`define DEST_CLRF    6'h30
`define DEST_SETF    6'h31
`define DEST_BR      6'h38
`define DEST_BN      6'h39
`define DEST_RETADDR 6'h3E
`define DEST_RETURN  6'h3F

// source space.
`define SRC_RETADDR   10'h03E
// top two source bits equal to this select a small constant.
`define SRC_SMALL_SEL 2'd2
`define SRC_AD0       10'h300
`define SRC_AND0      10'h330
`define SRC_OR0       10'h334
`define SRC_XOR0      10'h338
`define SRC_FLAGS     10'h340
`define SRC_SH1R      10'h350
`define SRC_SH1L      10'h351
`define SRC_SH4L      10'h352
`define SRC_SH4R      10'h353
`define SRC_NEG1      10'h360
`define SRC_IMM16     10'h3A0

// bit positions in the flags word.
`define FLAG_AND0_ZERO 0
`define FLAG_AD0_CARRY 1
`define FLAG_AD0_ZERO  2

`endif

// ==== logic/synapse_pkg.sv ====
`default_nettype none

`include "synapse_defines.svh"

package synapse_pkg;

    // plain move view of an instruction word.
    typedef struct packed {
        logic [`DEST_W-1:0] dest;
        logic [`SRC_W-1:0]  src;
    } move_fields_t;

    // small constant view of the same word.
    // the selector sits in the top two source bits.
    typedef struct packed {
        logic [`DEST_W-1:0] dest;
        logic [1:0]         sel;
        logic [`SRC_W-3:0]  value;
    } const_fields_t;

    // one instruction word, decoded either way.
    typedef union packed {
        move_fields_t  move;
        const_fields_t small_const;
    } instr_t;

    // flags word as seen on the transfer bus.
    // everything above the ad0 zero flag reads as one.
    typedef struct packed {
        logic [`WORD_W-4:0] ones;
        logic               ad0_zero;
        logic               ad0_carry;
        logic               and0_zero;
    } flags_t;

endpackage

`default_nettype wire

// ==== logic/fetch_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synapse_defines.svh"

module fetch_sequencer (
    input  wire                 sysreset,
    input  wire                 sysclk,
    input  wire [`WORD_W-1:0]   code_in,
    input  wire                 code_ready,
    input  wire                 selected_flag,
    output synapse_pkg::instr_t exec_instr,
    output logic                exec_en,
    output logic                jump_load,
    output logic                return_op,
    output logic                retaddr_load,
    output logic                clrf_op,
    output logic                setf_op,
    output logic                advance
);
    import synapse_pkg::*;

    // set on the first edge after reset, once address 0 went to the code memory.
    logic fetch_primed;
    // exec_instr holds a real word from the code memory.
    logic exr_valid;
    // exec_instr holds inline immediate data, not an opcode.
    logic imm_skip;
    // exec_instr holds a branch target or the word after a return.
    logic branch_skip;
    logic [`DEST_W-1:0] dest;
    logic imm_src;
    logic br_op;
    logic bn_op;

    assign dest = exec_instr.move.dest;

    // the pointer steps only while the code memory delivers.
    assign advance = code_ready && fetch_primed;

    // nothing executes during a stall or a skip cycle.
    assign exec_en = code_ready && exr_valid && !imm_skip && !branch_skip;

    // control operator decode.
    assign clrf_op      = exec_en && (dest == `DEST_CLRF);
    assign setf_op      = exec_en && (dest == `DEST_SETF);
    assign br_op        = exec_en && (dest == `DEST_BR);
    assign bn_op        = exec_en && (dest == `DEST_BN);
    assign retaddr_load = exec_en && (dest == `DEST_RETADDR);
    assign return_op    = exec_en && (dest == `DEST_RETURN);
    assign imm_src      = exec_en && (exec_instr.move.src == `SRC_IMM16);

    // br jumps on a set flag, bn on a clear one.
    // the target word is on code_in during the branch cycle.
    assign jump_load = (br_op && selected_flag) || (bn_op && !selected_flag);

    // control state.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            fetch_primed <= 1'b0;
            exr_valid    <= 1'b0;
            imm_skip     <= 1'b0;
            branch_skip  <= 1'b0;
        end else begin
            fetch_primed <= 1'b1;
            if (advance) begin
                exr_valid <= 1'b1;
            end
            // a skip holds through stalls and ends on the next ready edge.
            if (code_ready) begin
                imm_skip    <= imm_src;
                branch_skip <= br_op || bn_op || return_op;
            end
        end
    end

    // executing instruction register.
    // it follows code_in on every ready edge, skipped words included.
    always_ff @(posedge sysreset) begin
        if (advance) begin
            exec_instr <= code_in;
        end
    end

endmodule

`default_nettype wire

// ==== logic/instruction_pointer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synapse_defines.svh"

module instruction_pointer (
    input  wire                sysreset,
    input  wire                sysclk,
    input  wire [`WORD_W-1:0]  code_in,
    input  wire [`WORD_W-1:0]  move_data,
    input  wire                jump_load,
    input  wire                return_op,
    input  wire                retaddr_load,
    input  wire                advance,
    output logic [`IPR_W-1:0]  code_addr,
    output logic [`IPR_W-1:0]  return_addr
);

    // address of the word that code_in carries once the memory is ready.
    logic [`IPR_W-1:0] ipr;
    logic [`IPR_W-1:0] next_ipr;

    // next fetch address.
    // a taken branch fetches its target straight away, so only one word is skipped.
    always_comb begin
        if (!advance) begin
            next_ipr = ipr;
        end else if (jump_load) begin
            next_ipr = code_in;
        end else if (return_op) begin
            next_ipr = return_addr;
        end else begin
            next_ipr = ipr + 1'b1;
        end
    end

    // the memory samples this address on the coming edge.
    assign code_addr = next_ipr;

    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            ipr         <= '0;
            return_addr <= '0;
        end else begin
            ipr <= next_ipr;
            // return swaps, keeping the address of the word after the return.
            if (return_op) begin
                return_addr <= ipr;
            end else if (retaddr_load) begin
                return_addr <= move_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/operator_units.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synapse_defines.svh"

module operator_units (
    input  wire                 sysreset,
    input  wire                 sysclk,
    input  wire [`WORD_W-1:0]   r0,
    input  wire [`WORD_W-1:0]   r1,
    input  wire                 operand_load,
    input  wire                 clrf_op,
    input  wire                 setf_op,
    input  wire [`WORD_W-1:0]   move_data,
    input  wire [3:0]           flag_sel,
    output logic [`WORD_W-1:0]  ad0,
    output logic [`WORD_W-1:0]  and0,
    output logic [`WORD_W-1:0]  or0,
    output logic [`WORD_W-1:0]  xor0,
    output logic [`WORD_W-1:0]  sh1r,
    output logic [`WORD_W-1:0]  sh1l,
    output logic [`WORD_W-1:0]  sh4l,
    output logic [`WORD_W-1:0]  sh4r,
    output synapse_pkg::flags_t flags,
    output logic                selected_flag
);
    import synapse_pkg::*;

    // r0 or r1 was written on the last edge.
    logic add_pending;
    logic [`WORD_W:0] ad0_sum;
    logic [`WORD_W-1:0] and0_comb;
    logic carry;
    logic carry_base;
    logic ad0_zero;
    logic and0_zero;

    // the register file has the new operand by now.
    assign ad0_sum = {1'b0, r0} + {1'b0, r1} + {{`WORD_W{1'b0}}, carry};

    // the add lands before any setf or clrf in the same cycle.
    assign carry_base = add_pending ? ad0_sum[`WORD_W] : carry;

    assign and0_comb = r0 & r1;

    // ad0 and the carry chain.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            add_pending <= 1'b0;
            ad0         <= '0;
            ad0_zero    <= 1'b0;
            carry       <= 1'b0;
        end else begin
            add_pending <= operand_load;
            if (add_pending) begin
                ad0      <= ad0_sum[`WORD_W-1:0];
                ad0_zero <= (ad0_sum[`WORD_W-1:0] == '0);
            end
            // bit 0 of the moved value picks whether setf or clrf acts.
            if (setf_op) begin
                carry <= carry_base | move_data[0];
            end else if (clrf_op) begin
                carry <= carry_base & ~move_data[0];
            end else begin
                carry <= carry_base;
            end
        end
    end

    // bitwise units, sampled every cycle.
    always_ff @(posedge sysreset or posedge sysclk) begin
        if (sysclk) begin
            and0      <= '0;
            or0       <= '0;
            xor0      <= '0;
            and0_zero <= 1'b0;
        end else begin
            and0      <= and0_comb;
            or0       <= r0 | r1;
            xor0      <= r0 ^ r1;
            and0_zero <= (and0_comb == '0);
        end
    end

    // shifts of r0, zero filled.
    assign sh1r = {1'b0, r0[`WORD_W-1:1]};
    assign sh1l = {r0[`WORD_W-2:0], 1'b0};
    assign sh4l = {r0[`WORD_W-5:0], 4'b0};
    assign sh4r = {4'b0, r0[`WORD_W-1:4]};

    always_comb begin
        flags.ones      = '1;
        flags.ad0_zero  = ad0_zero;
        flags.ad0_carry = carry;
        flags.and0_zero = and0_zero;
    end

    // bits above the real flags are ones, so br on them always jumps.
    assign selected_flag = flags[flag_sel];

endmodule

`default_nettype wire

// ==== logic/transfer_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synapse_defines.svh"

module transfer_bus (
    input  wire synapse_pkg::instr_t     exec_instr,
    input  wire                          exec_en,
    input  wire [`NUM_REGS*`WORD_W-1:0]  r_data,
    input  wire [`WORD_W-1:0]            code_in,
    input  wire [`IPR_W-1:0]             return_addr,
    input  wire [`WORD_W-1:0]            ad0,
    input  wire [`WORD_W-1:0]            and0,
    input  wire [`WORD_W-1:0]            or0,
    input  wire [`WORD_W-1:0]            xor0,
    input  wire [`WORD_W-1:0]            sh1r,
    input  wire [`WORD_W-1:0]            sh1l,
    input  wire [`WORD_W-1:0]            sh4l,
    input  wire [`WORD_W-1:0]            sh4r,
    input  wire synapse_pkg::flags_t     flags,
    output logic [`WORD_W-1:0]           move_data,
    output logic [`NUM_REGS-1:0]         r_read,
    output logic [`NUM_REGS-1:0]         r_load,
    output logic                         operand_load
);
    import synapse_pkg::*;

    logic [`SRC_W-1:0]  src;
    logic [`DEST_W-1:0] dest;

    assign src  = exec_instr.move.src;
    assign dest = exec_instr.move.dest;

    // source multiplexer.
    always_comb begin
        move_data = '0;
        if (exec_instr.small_const.sel == `SRC_SMALL_SEL) begin
            // 0x200 to 0x2ff, zero extended 8-bit constant.
            move_data = {{(`WORD_W-`SRC_W+2){1'b0}}, exec_instr.small_const.value};
        end else if (src < `NUM_REGS) begin
            move_data = r_data[src*`WORD_W +: `WORD_W];
        end else begin
            case (src)
                `SRC_RETADDR: move_data = return_addr;
                `SRC_AD0:     move_data = ad0;
                `SRC_AND0:    move_data = and0;
                `SRC_OR0:     move_data = or0;
                `SRC_XOR0:    move_data = xor0;
                `SRC_FLAGS:   move_data = flags;
                `SRC_SH1R:    move_data = sh1r;
                `SRC_SH1L:    move_data = sh1l;
                `SRC_SH4L:    move_data = sh4l;
                `SRC_SH4R:    move_data = sh4r;
                `SRC_NEG1:    move_data = '1;
                // inline word following the opcode.
                `SRC_IMM16:   move_data = code_in;
                // unmapped sources read as zero.
                default:      move_data = '0;
            endcase
        end
    end

    // one read and one load strobe per register.
    for (genvar i = 0; i < `NUM_REGS; i++) begin : g_reg_strobe
        assign r_read[i] = exec_en && (src == i);
        assign r_load[i] = exec_en && (dest == i);
    end

    // writing either operand starts an add.
    assign operand_load = r_load[0] || r_load[1];

endmodule

`default_nettype wire

// ==== logic/synapse316.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synapse_defines.svh"

module synapse316 (
    input  wire                          sysreset,
    input  wire                          sysclk,
    output logic [`IPR_W-1:0]            code_addr,
    input  wire [`WORD_W-1:0]            code_in,
    input  wire                          code_ready,
    input  wire [`NUM_REGS*`WORD_W-1:0]  r_data,
    output logic [`NUM_REGS-1:0]         r_read,
    output logic [`NUM_REGS-1:0]         r_load,
    output logic [`WORD_W-1:0]           r_load_data
);
    import synapse_pkg::*;

    instr_t             exec_instr;
    flags_t             flags;
    logic               exec_en;
    logic               jump_load;
    logic               return_op;
    logic               retaddr_load;
    logic               clrf_op;
    logic               setf_op;
    logic               advance;
    logic               operand_load;
    logic               selected_flag;
    logic [`WORD_W-1:0] move_data;
    logic [`IPR_W-1:0]  return_addr;
    logic [`WORD_W-1:0] ad0;
    logic [`WORD_W-1:0] and0;
    logic [`WORD_W-1:0] or0;
    logic [`WORD_W-1:0] xor0;
    logic [`WORD_W-1:0] sh1r;
    logic [`WORD_W-1:0] sh1l;
    logic [`WORD_W-1:0] sh4l;
    logic [`WORD_W-1:0] sh4r;

    // every register write carries the moved word.
    assign r_load_data = move_data;

    fetch_sequencer u_fetch_sequencer (
        .sysreset      (sysreset),
        .sysclk        (sysclk),
        .code_in       (code_in),
        .code_ready    (code_ready),
        .selected_flag (selected_flag),
        .exec_instr    (exec_instr),
        .exec_en       (exec_en),
        .jump_load     (jump_load),
        .return_op     (return_op),
        .retaddr_load  (retaddr_load),
        .clrf_op       (clrf_op),
        .setf_op       (setf_op),
        .advance       (advance)
    );

    instruction_pointer u_instruction_pointer (
        .sysreset     (sysreset),
        .sysclk       (sysclk),
        .code_in      (code_in),
        .move_data    (move_data),
        .jump_load    (jump_load),
        .return_op    (return_op),
        .retaddr_load (retaddr_load),
        .advance      (advance),
        .code_addr    (code_addr),
        .return_addr  (return_addr)
    );

    // r0 and r1 are the operands. a branch picks its flag with the low source bits.
    operator_units u_operator_units (
        .sysreset      (sysreset),
        .sysclk        (sysclk),
        .r0            (r_data[`WORD_W-1:0]),
        .r1            (r_data[2*`WORD_W-1:`WORD_W]),
        .operand_load  (operand_load),
        .clrf_op       (clrf_op),
        .setf_op       (setf_op),
        .move_data     (move_data),
        .flag_sel      (exec_instr.move.src[3:0]),
        .ad0           (ad0),
        .and0          (and0),
        .or0           (or0),
        .xor0          (xor0),
        .sh1r          (sh1r),
        .sh1l          (sh1l),
        .sh4l          (sh4l),
        .sh4r          (sh4r),
        .flags         (flags),
        .selected_flag (selected_flag)
    );

    transfer_bus u_transfer_bus (
        .exec_instr   (exec_instr),
        .exec_en      (exec_en),
        .r_data       (r_data),
        .code_in      (code_in),
        .return_addr  (return_addr),
        .ad0          (ad0),
        .and0         (and0),
        .or0          (or0),
        .xor0         (xor0),
        .sh1r         (sh1r),
        .sh1l         (sh1l),
        .sh4l         (sh4l),
        .sh4r         (sh4r),
        .flags        (flags),
        .move_data    (move_data),
        .r_read       (r_read),
        .r_load       (r_load),
        .operand_load (operand_load)
    );

endmodule

`default_nettype wire

// ==== test/synapse_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synapse_defines.svh"

module synapse_checker #(
    parameter int mem_depth = 512
) (
    input  wire                          sysreset,
    input  wire                          sysclk,
    input  wire [`IPR_W-1:0]             code_addr,
    input  wire                          code_ready,
    input  wire [`NUM_REGS-1:0]          r_read,
    input  wire [`NUM_REGS-1:0]          r_load,
    input  wire [`WORD_W-1:0]            r_load_data,
    input  wire [`NUM_REGS*`WORD_W-1:0]  r_data,
    input  wire [mem_depth*`WORD_W-1:0]  code_image,
    output logic                         done,
    output logic [31:0]                  error_count,
    output logic [31:0]                  write_count,
    output logic [31:0]                  fetch_count
);

    // expected fetch addresses, register reads and register writes, in order.
    int                 exp_fetch [$];
    int                 exp_read [$];
    int                 exp_reg [$];
    logic [`WORD_W-1:0] exp_data [$];
    logic               model_ready;
    logic               latch_valid;
    logic [`IPR_W-1:0]  latched_addr;

    function automatic logic [`WORD_W-1:0] word_at(input int a);
        return code_image[a*`WORD_W +: `WORD_W];
    endfunction

    // architectural run of the whole program.
    task automatic run_model();
        logic [`WORD_W-1:0] regs [`NUM_REGS];
        logic [`WORD_W-1:0] w, data, ret, ad0, flags_w;
        logic [`WORD_W:0]   sum;
        logic [5:0]         dest;
        logic [9:0]         src;
        logic               carry, ad0_zero, halt;
        int                 pc, next;
        for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] = r_data[i*`WORD_W +: `WORD_W];
        end
        pc = 0;
        ret = '0;
        ad0 = '0;
        carry = 1'b0;
        ad0_zero = 1'b0;
        halt = 1'b0;
        while (!halt) begin
            w = word_at(pc);
            dest = w[15:10];
            src = w[9:0];
            exp_fetch.push_back(pc);
            flags_w = {13'h1fff, ad0_zero, carry, (regs[0] & regs[1]) == '0};
            if (src[9:8] == `SRC_SMALL_SEL) begin
                data = {8'b0, src[7:0]};
            end else if (src < `NUM_REGS) begin
                data = regs[src];
            end else begin
                case (src)
                    `SRC_RETADDR: data = ret;
                    `SRC_AD0:     data = ad0;
                    `SRC_AND0:    data = regs[0] & regs[1];
                    `SRC_OR0:     data = regs[0] | regs[1];
                    `SRC_XOR0:    data = regs[0] ^ regs[1];
                    `SRC_FLAGS:   data = flags_w;
                    `SRC_SH1R:    data = regs[0] >> 1;
                    `SRC_SH1L:    data = regs[0] << 1;
                    `SRC_SH4L:    data = regs[0] << 4;
                    `SRC_SH4R:    data = regs[0] >> 4;
                    `SRC_NEG1:    data = '1;
                    `SRC_IMM16:   data = word_at(pc + 1);
                    default:      data = '0;
                endcase
            end
            // every executed word with a register source strobes that read line.
            if (src < `NUM_REGS) begin
                exp_read.push_back(src);
            end
            next = pc + 1;
            // two-word instructions also fetch the following word.
            if (src == `SRC_IMM16 || dest == `DEST_BR || dest == `DEST_BN
                    || dest == `DEST_RETURN) begin
                exp_fetch.push_back(pc + 1);
                next = pc + 2;
            end
            if (dest < `NUM_REGS) begin
                regs[dest] = data;
                exp_reg.push_back(dest);
                exp_data.push_back(data);
                // an operand write triggers ad0 with the carry.
                if (dest < 2) begin
                    sum = regs[0] + regs[1] + carry;
                    ad0 = sum[`WORD_W-1:0];
                    carry = sum[`WORD_W];
                    ad0_zero = (ad0 == '0);
                end
            end else if (dest == `DEST_SETF) begin
                carry = carry | data[0];
            end else if (dest == `DEST_CLRF) begin
                carry = carry & ~data[0];
            end else if (dest == `DEST_RETADDR) begin
                ret = data;
            end else if (dest == `DEST_RETURN) begin
                next = ret;
                ret = pc + 1;
            end else if (dest == `DEST_BR || dest == `DEST_BN) begin
                if (flags_w[src[3:0]] ^ (dest == `DEST_BN)) begin
                    next = word_at(pc + 1);
                    halt = (next == pc);
                end
            end
            pc = next;
        end
    endtask

    initial begin
        model_ready = 1'b0;
        error_count = 0;
        write_count = 0;
        fetch_count = 0;
        done = 1'b0;
        @(negedge sysclk);
        run_model();
        model_ready = 1'b1;
    end

    task automatic check_write();
        logic [`NUM_REGS-1:0] exp_load;
        if ($countones(r_load) != 1) begin
            $display("more than one register loaded at once at %0t", $time);
            error_count++;
        end else if (exp_reg.size() == 0) begin
            $display("register write after the end of the program at %0t", $time);
            error_count++;
        end else begin
            exp_load = 1 << exp_reg.pop_front();
            if (r_load !== exp_load) begin
                $display("Fail at %0t: r_load expected %b got %b", $time, exp_load, r_load);
                error_count++;
            end
            if (r_load_data !== exp_data[0]) begin
                $display("Fail at %0t: r_load_data expected %h got %h",
                         $time, exp_data[0], r_load_data);
                error_count++;
            end
            void'(exp_data.pop_front());
            write_count++;
        end
    endtask

    task automatic check_read();
        logic [`NUM_REGS-1:0] exp_strobe;
        if (exp_read.size() == 0) begin
            $display("register read after the end of the program at %0t", $time);
            error_count++;
        end else begin
            exp_strobe = 1 << exp_read.pop_front();
            if (r_read !== exp_strobe) begin
                $display("Fail at %0t: r_read expected %b got %b", $time, exp_strobe, r_read);
                error_count++;
            end
        end
    endtask

    // a word is consumed on each ready edge after the address was latched.
    always @(posedge sysreset) begin
        if (sysclk) begin
            latch_valid <= 1'b0;
        end else if (model_ready) begin
            if (latch_valid && code_ready && exp_fetch.size() != 0) begin
                if (latched_addr !== exp_fetch[0]) begin
                    $display("Fail at %0t: code_addr expected %h got %h",
                             $time, exp_fetch[0][15:0], latched_addr);
                    error_count++;
                end
                void'(exp_fetch.pop_front());
                fetch_count++;
            end
            latched_addr <= code_addr;
            latch_valid <= 1'b1;
            if (r_read != '0) begin
                check_read();
            end
            if (r_load != '0) begin
                check_write();
            end
            done <= (exp_fetch.size() == 0) && (exp_reg.size() == 0)
                    && (exp_read.size() == 0);
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_synapse316.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synapse_defines.svh"

module tb_synapse316;

    localparam int mem_depth = 512;
    // operator results that a random move may read.
    localparam logic [9:0] unit_srcs [11] = '{`SRC_AD0, `SRC_AND0, `SRC_OR0, `SRC_XOR0,
        `SRC_FLAGS, `SRC_SH1R, `SRC_SH1L, `SRC_SH4L, `SRC_SH4R, `SRC_NEG1, `SRC_RETADDR};

    // sysreset is the clock and sysclk the reset.
    logic                          sysreset;
    logic                          sysclk;
    logic [`IPR_W-1:0]             code_addr;
    logic [`WORD_W-1:0]            code_in;
    logic                          code_ready;
    logic [`NUM_REGS*`WORD_W-1:0]  r_data;
    logic [`NUM_REGS-1:0]          r_read;
    logic [`NUM_REGS-1:0]          r_load;
    logic [`WORD_W-1:0]            r_load_data;
    // code memory, one word per 16 bits.
    logic [mem_depth*`WORD_W-1:0]  code_image;
    logic [`IPR_W-1:0]             fetch_addr;
    logic [31:0]                   rng;
    logic                          built;
    logic                          done;
    logic [31:0]                   error_count;
    logic [31:0]                   write_count;
    logic [31:0]                   fetch_count;
    int                            prog_len;

    synapse316 u_synapse316 (
        .sysreset    (sysreset),
        .sysclk      (sysclk),
        .code_addr   (code_addr),
        .code_in     (code_in),
        .code_ready  (code_ready),
        .r_data      (r_data),
        .r_read      (r_read),
        .r_load      (r_load),
        .r_load_data (r_load_data)
    );

    synapse_checker u_checker (
        .sysreset    (sysreset),
        .sysclk      (sysclk),
        .code_addr   (code_addr),
        .code_ready  (code_ready),
        .r_read      (r_read),
        .r_load      (r_load),
        .r_load_data (r_load_data),
        .r_data      (r_data),
        .code_image  (code_image),
        .done        (done),
        .error_count (error_count),
        .write_count (write_count),
        .fetch_count (fetch_count)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic emit(input logic [`WORD_W-1:0] w);
        code_image[prog_len*`WORD_W +: `WORD_W] = w;
        prog_len++;
    endtask

    // harmless small constant into r7.
    task automatic emit_filler();
        emit({6'd7, 2'b10, rng[23:16]});
    endtask

    task automatic build_program();
        logic [5:0] d;
        int kind;
        prog_len = 0;
        while (prog_len < mem_depth - 16) begin
            rng = next_rand(rng);
            kind = rng[2:0];
            d = {3'b0, rng[5:3]};
            case (kind)
                0: emit({d, 7'b0, rng[10:8]});
                1: emit({d, 2'b10, rng[15:8]});
                2: emit({d, `SRC_NEG1});
                3: begin
                    emit({d, `SRC_IMM16});
                    emit(rng[31:16]);
                end
                4: emit({d, unit_srcs[rng[11:8] % 11]});
                5: emit({rng[8] ? `DEST_SETF : `DEST_CLRF, 2'b10, 7'b0, rng[9]});
                6: begin
                    // flag 0 to 2, or bit 15 which always reads one.
                    emit({rng[8] ? `DEST_BR : `DEST_BN, 6'b0,
                          rng[10:9] == 2'd3 ? 4'hf : {2'b0, rng[10:9]}});
                    // target jumps over two fillers.
                    emit(prog_len + 3);
                    emit_filler();
                    emit_filler();
                end
                default: begin
                    emit({`DEST_RETADDR, `SRC_IMM16});
                    emit(prog_len + 4);
                    emit({`DEST_RETURN, 10'h200});
                    emit_filler();
                    emit_filler();
                    // reads back the address after the return.
                    emit({6'd6, `SRC_RETADDR});
                end
            endcase
            // results need one cycle after an operand write.
            if (kind <= 4 && d < 2) begin
                emit_filler();
            end
        end
        // final self loop.
        emit({`DEST_BR, 10'h00F});
        emit(prog_len - 1);
    endtask

    always #4 sysreset = ~sysreset;

    // one-cycle code memory.
    always @(posedge sysreset) begin
        fetch_addr <= code_addr;
        for (int i = 0; i < `NUM_REGS; i++) begin
            if (r_load[i]) begin
                r_data[i*`WORD_W +: `WORD_W] <= r_load_data;
            end
        end
    end

    // random stalls, junk on code_in while not ready.
    always @(negedge sysreset) begin
        rng = next_rand(rng);
        code_ready <= (rng[1:0] != 2'd0);
        code_in <= (rng[1:0] != 2'd0) ? code_image[fetch_addr*`WORD_W +: `WORD_W] : rng[31:16];
    end

    initial begin
        wait (built);
        #(prog_len * 4 * 8 + 2000);
        $display("timeout: the checker never saw the end of the program");
        $display("errors %0d, writes %0d, fetches %0d", error_count, write_count, fetch_count);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rng = 32'd61251;
        built = 1'b0;
        sysreset = 1'b0;
        sysclk = 1'b1;
        code_ready = 1'b0;
        code_in = '0;
        fetch_addr = '0;
        code_image = '0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            rng = next_rand(rng);
            r_data[i*`WORD_W +: `WORD_W] = rng[15:0];
        end
        build_program();
        built = 1'b1;
        repeat (4) @(posedge sysreset);
        @(negedge sysreset);
        sysclk = 1'b0;
        wait (done);
        repeat (2) @(posedge sysreset);
        $display("errors %0d, writes %0d, fetches %0d", error_count, write_count, fetch_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/synapse_pkg.sv
logic/fetch_sequencer.sv
logic/instruction_pointer.sv
logic/operator_units.sv
logic/transfer_bus.sv
logic/synapse316.sv
test/synapse_checker.sv
test/tb_synapse316.sv
